// File: common/des_settings.svh
`ifndef DES_SETTINGS_SVH
`define DES_SETTINGS_SVH

// ****************************************************************************
// widths of the key path
// ****************************************************************************

`define DES_KEY_W      64 // key as it enters, parity bits included.
`define DES_CD_W       56 // key after PC-1, C and D side by side.
`define DES_HALF_W     28 // one of the two rotating halves.
`define DES_SUBKEY_W   48 // round key after PC-2.

// ****************************************************************************
// round count and timing
// ****************************************************************************

`define DES_ROUNDS     16
`define DES_ROUND_W    4  // holds the round index 0 to 15.

// the sixteenth round key is the one that carries oflag.
`define DES_LAST_ROUND (`DES_ROUNDS - 1)

// bit i is set when round i+1 rotates by one place, the other rounds rotate
// by two. Rounds 1, 2, 9 and 16 are the short ones.
`define DES_SHIFT_ONE_MASK 16'h8103

`endif

// File: common/des_pkg.sv
`include "des_settings.svh"

package des_pkg;

	// ************************************************************************
	// vector types
	// ************************************************************************

	// bit numbering follows the DES standard, bit 1 is the most significant
	// one, so the permutation tables can be read straight off the standard.
	typedef logic [1:`DES_KEY_W] key_t;

	typedef logic [1:`DES_HALF_W] half_t; // a C or a D half.

	typedef logic [1:`DES_SUBKEY_W] subkey_t; // K1 to K16.

	// round index, 0 stands for K1 and 15 for K16.
	typedef logic [`DES_ROUND_W-1:0] round_t;

	// ************************************************************************
	// scheduler FSM
	// ************************************************************************

	typedef enum logic {
		IDLE, // waits for start.
		RUN   // one round key per clock.
	} sched_state_t;

endpackage

// File: key_sched/key_sched_ctrl.sv
`timescale 1ns/10ps
`include "des_settings.svh"

module key_sched_ctrl import des_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   start,
	input  logic   mode,
	output logic   busy,
	output logic   load,
	output logic   rotate,
	output logic   shift_two,
	output logic   rot_right,
	output logic   capture,
	output round_t cap_round,
	output logic   cap_last
);

	localparam round_t LAST_ROUND = round_t'(`DES_LAST_ROUND);
	localparam logic [`DES_ROUNDS-1:0] SHIFT_ONE = `DES_SHIFT_ONE_MASK;

	sched_state_t state;
	round_t       round_cnt; // counts captures, 0 to 15.
	logic         mode_q;
	round_t       shift_idx;

	// ************************************************************************
	// state machine and round counter
	// ************************************************************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= IDLE;
			round_cnt <= '0;
			mode_q    <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						state     <= RUN;
						round_cnt <= '0;
						mode_q    <= mode; // held for the whole schedule.
					end
				end
				RUN: begin
					round_cnt <= round_cnt + round_t'(1);
					if (round_cnt == LAST_ROUND) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// ************************************************************************
	// strobes to the datapath
	// ************************************************************************

	assign busy    = (state == RUN);
	assign load    = start && (state == IDLE); // a start while busy is dropped.
	assign capture = (state == RUN);

	// the register already holds the last C and D when the last key is taken.
	assign rotate   = (state == RUN) && (round_cnt != LAST_ROUND);
	assign cap_last = (round_cnt == LAST_ROUND);

	// while idle the direction has to follow the live mode input, since the
	// load rotation happens before mode_q is written.
	assign rot_right = (state == IDLE) ? mode : mode_q;

	// the rotation in this cycle builds the C and D of the next key. Going
	// forward that is round cnt+2, going backward we undo round 16-cnt.
	assign shift_idx = mode_q ? (LAST_ROUND - round_cnt) : (round_cnt + round_t'(1));
	assign shift_two = !SHIFT_ONE[shift_idx];

	// decrypt hands out K16 first, so the round number runs down.
	assign cap_round = mode_q ? (LAST_ROUND - round_cnt) : round_cnt;

endmodule

// File: key_sched/cd_rotator.sv
`timescale 1ns/10ps
`include "des_settings.svh"

module cd_rotator import des_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  key_t  key,
	input  logic  load,
	input  logic  rotate,
	input  logic  shift_two,
	input  logic  rot_right,
	output half_t c_half,
	output half_t d_half
);

	// ************************************************************************
	// PC-1, entry i names the key bit that lands on position i+1
	// ************************************************************************

	localparam int PC1 [`DES_CD_W] = '{
		57, 49, 41, 33, 25, 17,  9,
		 1, 58, 50, 42, 34, 26, 18,
		10,  2, 59, 51, 43, 35, 27,
		19, 11,  3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15,
		 7, 62, 54, 46, 38, 30, 22,
		14,  6, 61, 53, 45, 37, 29,
		21, 13,  5, 28, 20, 12,  4
	};

	logic [1:`DES_CD_W] key_pc1;
	half_t              c_pc1;
	half_t              d_pc1;

	// the eighth bit of every key byte is parity and is not in the table.
	always_comb begin
		for (int i = 0; i < `DES_CD_W; i++) begin
			key_pc1[i + 1] = key[PC1[i]];
		end
	end

	assign c_pc1 = key_pc1[1:`DES_HALF_W];
	assign d_pc1 = key_pc1[`DES_HALF_W+1:`DES_CD_W];

	// ************************************************************************
	// rotation of one half
	// ************************************************************************

	// left moves bits toward bit 1, the way the standard rotates.
	function automatic half_t rot_half(input half_t h, input logic right,
		input logic two);
		half_t r;
		case ({right, two})
			2'b00:   r = {h[2:`DES_HALF_W], h[1]};
			2'b01:   r = {h[3:`DES_HALF_W], h[1:2]};
			2'b10:   r = {h[`DES_HALF_W], h[1:`DES_HALF_W-1]};
			default: r = {h[`DES_HALF_W-1:`DES_HALF_W], h[1:`DES_HALF_W-2]};
		endcase
		return r;
	endfunction

	// ************************************************************************
	// C and D registers
	// ************************************************************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			c_half <= '0;
			d_half <= '0;
		end else if (load) begin
			if (rot_right) begin
				// the 28 places of all rounds add up to a full turn, so C16 is C0.
				c_half <= c_pc1;
				d_half <= d_pc1;
			end else begin
				c_half <= rot_half(c_pc1, 1'b0, 1'b0); // round 1 shifts by one.
				d_half <= rot_half(d_pc1, 1'b0, 1'b0);
			end
		end else if (rotate) begin
			c_half <= rot_half(c_half, rot_right, shift_two);
			d_half <= rot_half(d_half, rot_right, shift_two);
		end
	end

endmodule

// File: key_sched/subkey_select.sv
`timescale 1ns/10ps
`include "des_settings.svh"

module subkey_select import des_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  half_t   c_half,
	input  half_t   d_half,
	input  logic    capture,
	input  round_t  cap_round,
	input  logic    cap_last,
	output subkey_t subkey,
	output round_t  subkey_round,
	output logic    subkey_valid,
	output logic    oflag
);

	// ************************************************************************
	// PC-2 over the joined C and D, positions counted from 1
	// ************************************************************************

	localparam int PC2 [`DES_SUBKEY_W] = '{
		14, 17, 11, 24,  1,  5,
		 3, 28, 15,  6, 21, 10,
		23, 19, 12,  4, 26,  8,
		16,  7, 27, 20, 13,  2,
		41, 52, 31, 37, 47, 55,
		30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53,
		46, 42, 50, 36, 29, 32
	};

	logic [1:`DES_CD_W] cd;
	subkey_t            key_pc2;

	assign cd = {c_half, d_half};

	// C feeds the first 24 key bits and D the last 24, eight bits are dropped.
	always_comb begin
		for (int i = 0; i < `DES_SUBKEY_W; i++) begin
			key_pc2[i + 1] = cd[PC2[i]];
		end
	end

	// ************************************************************************
	// output register
	// ************************************************************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			subkey       <= '0;
			subkey_round <= '0;
		end else if (capture) begin
			subkey       <= key_pc2;
			subkey_round <= cap_round; // round of the key now in subkey.
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			subkey_valid <= 1'b0;
			oflag        <= 1'b0;
		end else begin
			subkey_valid <= capture;
			oflag        <= capture && cap_last; // last key of the schedule.
		end
	end

endmodule

// File: key_sched/des_key_sched.sv
`timescale 1ns/10ps

module des_key_sched import des_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  logic    start,
	input  logic    mode,         // 0 encrypts, 1 decrypts.
	input  key_t    key,
	output subkey_t subkey,
	output round_t  subkey_round,
	output logic    subkey_valid,
	output logic    oflag,
	output logic    busy
);

	logic   load;
	logic   rotate;
	logic   shift_two;
	logic   rot_right;
	logic   capture;
	round_t cap_round;
	logic   cap_last;
	half_t  c_half;
	half_t  d_half;

	key_sched_ctrl i_ctrl (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (start),
		.mode      (mode),
		.busy      (busy),
		.load      (load),
		.rotate    (rotate),
		.shift_two (shift_two),
		.rot_right (rot_right),
		.capture   (capture),
		.cap_round (cap_round),
		.cap_last  (cap_last)
	);

	cd_rotator i_cd_rotator (
		.clk       (clk),
		.arst_n    (arst_n),
		.key       (key),
		.load      (load),
		.rotate    (rotate),
		.shift_two (shift_two),
		.rot_right (rot_right),
		.c_half    (c_half),
		.d_half    (d_half)
	);

	subkey_select i_subkey_select (
		.clk          (clk),
		.arst_n       (arst_n),
		.c_half       (c_half),
		.d_half       (d_half),
		.capture      (capture),
		.cap_round    (cap_round),
		.cap_last     (cap_last),
		.subkey       (subkey),
		.subkey_round (subkey_round),
		.subkey_valid (subkey_valid),
		.oflag        (oflag)
	);

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk,
	output logic arst_n
);

	localparam int HALF_PERIOD  = 20; // 40 ns period.
	localparam int RESET_CYCLES = 10;

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD clk = ~clk;
		end
	end

	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		arst_n = 1'b1; // released just after an edge, like the other inputs.
	end

endmodule

// File: verification/tb_des_key_sched.sv
`timescale 1ns/10ps
`include "des_settings.svh"

module tb_des_key_sched import des_pkg::*; ();

	// ************************************************************************
	// DES tables for the reference key schedule
	// ************************************************************************

	localparam int PC1_TAB [56] = '{
		57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
		10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
		14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
	};
	localparam int PC2_TAB [48] = '{
		14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
		23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
		41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
	};
	localparam int SHIFT_TAB [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

	localparam int DRIVE_DELAY = 1;
	localparam int WAIT_LIMIT  = 40; // cycles before a wait gives up.
	localparam key_t KAT_KEY   = 64'h133457799BBCDFF1;
	localparam key_t PARITY    = 64'h0101010101010101; // bits 8, 16, ... 64.

	logic    clk;
	logic    arst_n;
	logic    start;
	logic    mode;
	key_t    key;
	subkey_t subkey;
	round_t  subkey_round;
	logic    subkey_valid;
	logic    oflag;
	logic    busy;

	subkey_t model_keys [1:16]; // K1 to K16 for encryption.
	subkey_t got_keys [16];
	round_t  got_rounds [16];
	logic    got_oflag [16];
	int      got_count;
	int      first_cyc;
	int      last_cyc;
	int      extra_valid;
	logic    busy_early;
	logic    busy_at_flag;
	int      errors;
	int      checks;
	int      tests;

	tb_clock_gen i_clock_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	des_key_sched i_dut (
		.clk          (clk),
		.arst_n       (arst_n),
		.start        (start),
		.mode         (mode),
		.key          (key),
		.subkey       (subkey),
		.subkey_round (subkey_round),
		.subkey_valid (subkey_valid),
		.oflag        (oflag),
		.busy         (busy)
	);

	// ************************************************************************
	// reference model and checking
	// ************************************************************************

	task automatic build_model(input key_t k);
		logic [1:56] cd;
		logic [1:28] c;
		logic [1:28] d;
		subkey_t     sk;
		for (int i = 0; i < 56; i++) begin
			cd[i + 1] = k[PC1_TAB[i]];
		end
		c = cd[1:28];
		d = cd[29:56];
		for (int r = 0; r < 16; r++) begin
			for (int s = 0; s < SHIFT_TAB[r]; s++) begin
				c = {c[2:28], c[1]}; // one place left per step.
				d = {d[2:28], d[1]};
			end
			cd = {c, d};
			for (int j = 0; j < 48; j++) begin
				sk[j + 1] = cd[PC2_TAB[j]];
			end
			model_keys[r + 1] = sk;
		end
	endtask

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("%s: passed", name);
		end else begin
			$display("%s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	// starts one schedule and records every valid key until oflag. A second
	// start with another mode and key goes in at cycle restart_at.
	task automatic run_schedule(input key_t k, input logic m, input int restart_at);
		int   cyc;
		logic done;
		got_count    = 0;
		first_cyc    = -1;
		last_cyc     = -1;
		extra_valid  = 0;
		busy_early   = 1'b0;
		busy_at_flag = 1'b1;
		done         = 1'b0;
		cyc          = 0;
		@(posedge clk);
		#DRIVE_DELAY;
		start = 1'b1;
		mode  = m;
		key   = k;
		@(negedge clk);
		while (!done && cyc < WAIT_LIMIT) begin
			cyc++;
			@(posedge clk);
			#DRIVE_DELAY;
			start = (cyc == restart_at);
			if (cyc == restart_at) begin
				mode = ~m;
				key  = ~k;
			end
			@(negedge clk);
			if (cyc == 1) begin
				busy_early = busy;
			end
			if (subkey_valid) begin
				if (got_count == 0) begin
					first_cyc = cyc;
				end
				if (got_count < 16) begin
					got_keys[got_count]   = subkey;
					got_rounds[got_count] = subkey_round;
					got_oflag[got_count]  = oflag;
				end
				got_count++;
				last_cyc = cyc;
			end
			if (oflag) begin
				done         = 1'b1;
				busy_at_flag = busy;
			end
		end
		start = 1'b0;
		if (!done) begin
			errors++;
			$display("timeout waiting for subkey_valid");
		end
		for (int n = 0; n < 4; n++) begin
			@(negedge clk);
			if (subkey_valid) begin
				extra_valid++;
			end
		end
	endtask

	task automatic verify_schedule(input logic m);
		int exp_round;
		compare_value("subkey_valid delay", 64'(first_cyc), 64'd2);
		compare_value("subkey count", 64'(got_count), 64'd16);
		compare_value("subkey_valid last cycle", 64'(last_cyc), 64'd17);
		compare_value("busy after start", 64'(busy_early), 64'd1);
		compare_value("busy at oflag", 64'(busy_at_flag), 64'd0);
		compare_value("extra subkey_valid", 64'(extra_valid), 64'd0);
		for (int i = 0; i < 16 && i < got_count; i++) begin
			exp_round = m ? 15 - i : i;
			compare_value($sformatf("subkey[%0d]", i), 64'(got_keys[i]),
				64'(model_keys[exp_round + 1]));
			compare_value($sformatf("subkey_round[%0d]", i), 64'(got_rounds[i]),
				64'(exp_round));
			compare_value($sformatf("oflag[%0d]", i), 64'(got_oflag[i]), 64'(i == 15));
		end
	endtask

	// ************************************************************************
	// directed tests
	// ************************************************************************

	task automatic idle_after_reset();
		int n;
		int errs;
		errs = errors;
		n    = 0;
		while (arst_n !== 1'b1 && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (arst_n !== 1'b1) begin
			errors++;
			$display("timeout waiting for reset to be released");
		end
		repeat (3) begin
			@(negedge clk);
			compare_value("subkey_valid", 64'(subkey_valid), 64'd0);
			compare_value("oflag", 64'(oflag), 64'd0);
			compare_value("busy", 64'(busy), 64'd0);
			compare_value("subkey", 64'(subkey), 64'd0);
		end
		report_test("reset state", errs);
	endtask

	task automatic encrypt_known_answer();
		int errs;
		errs = errors;
		build_model(KAT_KEY);
		compare_value("model K1", 64'(model_keys[1]), 64'h1B02EFFC7072);
		compare_value("model K16", 64'(model_keys[16]), 64'hCB3D8B0E17F5);
		run_schedule(KAT_KEY, 1'b0, -1);
		verify_schedule(1'b0);
		report_test("known answer, encrypt", errs);
	endtask

	task automatic decrypt_key_order();
		int errs;
		errs = errors;
		build_model(KAT_KEY);
		run_schedule(KAT_KEY, 1'b1, -1);
		verify_schedule(1'b1); // K16 comes first.
		report_test("decrypt order", errs);
	endtask

	task automatic random_key_sweep();
		key_t k;
		logic m;
		int   errs;
		errs = errors;
		for (int i = 0; i < 20; i++) begin
			k = {$urandom(), $urandom()};
			m = i[0];
			build_model(k);
			run_schedule(k, m, -1);
			verify_schedule(m);
		end
		report_test("random keys", errs);
	endtask

	task automatic parity_and_restart();
		key_t k;
		int   errs;
		errs = errors;
		k = {$urandom(), $urandom()};
		build_model(k);
		run_schedule(k ^ PARITY, 1'b0, -1);
		verify_schedule(1'b0);
		run_schedule(k ^ PARITY, 1'b1, -1);
		verify_schedule(1'b1);
		run_schedule(k, 1'b0, 5); // restart lands while busy.
		verify_schedule(1'b0);
		report_test("parity bits and restart while busy", errs);
	endtask

	initial begin
		start  = 1'b0;
		mode   = 1'b0;
		key    = '0;
		errors = 0;
		checks = 0;
		tests  = 0;
		void'($urandom(32'h722b));
		idle_after_reset();
		encrypt_known_answer();
		decrypt_key_order();
		random_key_sweep();
		parity_and_restart();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+common
common/des_pkg.sv
key_sched/key_sched_ctrl.sv
key_sched/cd_rotator.sv
key_sched/subkey_select.sv
key_sched/des_key_sched.sv
verification/tb_clock_gen.sv
verification/tb_des_key_sched.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide on the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f verilog.f --top-module tb_des_key_sched -Mdir obj_dir \
	&& ./obj_dir/Vtb_des_key_sched > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^NO ERRORS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
